//--- logic/audio_rx_defs.svh
// ------------------------------------------------
// Audio receive defines
// Destination port, default FIFO size and default
// playout period for the audio stream receiver
// ------------------------------------------------

`ifndef AUDIO_RX_DEFS_SVH
`define AUDIO_RX_DEFS_SVH

`default_nettype none

// Destination port that carries audio payload
`define AUDIO_DEST_PORT 8'h10

// Default FIFO address width, 4096 samples deep
`define FIFO_ADDR_W_DEFAULT 12

// Clock cycles per output sample
// 50 MHz / 1134 gives roughly 44.1 kSps
`define PLAY_PERIOD_DEFAULT 1134

`default_nettype wire

`endif

//--- logic/audioRxPkg.sv
// ------------------------------------------------
// Audio receive package
// Width types and stream structs shared by the
// receive path and its testbench
// ------------------------------------------------

`default_nettype none

package audioRxPkg;

  // One byte of the serial stream
  typedef logic [7:0] byteT;

  // Destination port number
  typedef logic [7:0] portT;

  // Packet length in bytes, sop beat included
  typedef logic [7:0] pktLenT;

  // One 16-bit audio sample
  typedef logic [15:0] sampleT;

  // One beat of the incoming packet stream
  // Destination and length only hold on the sop beat
  typedef struct packed {
    logic   valid;
    logic   sop;
    portT   destination;
    pktLenT length;
    byteT   data;
  } rxPacketT;

  // Single write into the sample FIFO
  typedef struct packed {
    logic   valid;
    sampleT data;
  } sampleWriteT;

  // Played-out sample, valid for one cycle
  typedef struct packed {
    logic   valid;
    sampleT data;
  } audioSampleT;

endpackage

`default_nettype wire

//--- logic/sampleAssembler.sv
// ------------------------------------------------
// Sample assembler
// Picks audio packets out of the byte stream and
// pairs bytes into little-endian sample writes
// ------------------------------------------------

`timescale 1ns/1ps
`include "audio_rx_defs.svh"
`default_nettype none

module sampleAssembler
  import audioRxPkg::*;
(
  input  wire         ipClk,
  input  wire         rstN,
  input  rxPacketT    rxStream,
  output sampleWriteT sampleWr
);

  // Packet tracking FSM
  typedef enum logic [0:0] {
    stIdle,
    stReceiving
  } asmStateT;

  asmStateT state;

  // Bytes still to come in the current packet
  pktLenT remaining;

  // High when the next payload byte is the high half
  logic highNext;

  // Low byte waiting for its partner
  byteT lowByte;

  // Registered write towards the FIFO
  logic   wrValid;
  sampleT wrData;

  logic startBeat;
  logic destHit;
  logic bodyBeat;

  // First beat of any packet
  assign startBeat = rxStream.valid && rxStream.sop;

  // Only the audio port is of interest
  assign destHit = (rxStream.destination == `AUDIO_DEST_PORT);

  // Continuation byte of an accepted packet
  assign bodyBeat = (state == stReceiving) && rxStream.valid && !rxStream.sop;

  always_ff @(posedge ipClk) begin
    if (!rstN) begin
      state     <= stIdle;
      remaining <= '0;
      highNext  <= 1'b0;
      wrValid   <= 1'b0;
    end else begin
      // Write strobe lasts one cycle
      wrValid <= 1'b0;

      if (startBeat) begin
        // A new sop always restarts the tracking
        // The sop beat carries the low byte
        highNext  <= 1'b1;
        remaining <= rxStream.length - pktLenT'(1);
        // Single-byte packets have nothing to pair with
        if (destHit && (rxStream.length > pktLenT'(1))) begin
          state <= stReceiving;
        end else begin
          state <= stIdle;
        end
      end else if (bodyBeat) begin
        // Completed pair goes out next cycle
        if (highNext) begin
          wrValid <= 1'b1;
        end
        highNext  <= !highNext;
        remaining <= remaining - pktLenT'(1);
        // Last byte of the packet
        // an unpaired low byte is simply left behind
        if (remaining == pktLenT'(1)) begin
          state <= stIdle;
        end
      end
    end
  end

  // Payload path
  always_ff @(posedge ipClk) begin
    if (startBeat) begin
      lowByte <= rxStream.data;
    end else if (bodyBeat) begin
      if (highNext) begin
        // Little endian with the low byte first
        wrData <= {rxStream.data, lowByte};
      end else begin
        lowByte <= rxStream.data;
      end
    end
  end

  assign sampleWr = '{valid: wrValid, data: wrData};

endmodule

`default_nettype wire

//--- logic/sampleFifo.sv
// ------------------------------------------------
// Sample FIFO
// Dual-port RAM buffer with registered head read,
// free space report in bytes and overflow flag
// ------------------------------------------------

`timescale 1ns/1ps
`include "audio_rx_defs.svh"
`default_nettype none

module sampleFifo
  import audioRxPkg::*;
#(
  parameter int fifoAddrW = `FIFO_ADDR_W_DEFAULT
) (
  input  wire                  ipClk,
  input  wire                  rstN,
  input  sampleWriteT          sampleWr,
  input  wire                  pop,
  output sampleT               headData,
  output logic                 fifoEmpty,
  output logic [fifoAddrW+1:0] fifoSpace,
  output logic                 overflow
);

  localparam int depth = 1 << fifoAddrW;

  // Depth as a level-width constant
  localparam logic [fifoAddrW:0] depthLvl = (fifoAddrW + 1)'(depth);

  // Inferred RAM
  sampleT mem [depth];

  // One extra bit tells full from empty
  logic [fifoAddrW:0] wrPtr;
  logic [fifoAddrW:0] rdPtr;
  logic [fifoAddrW:0] level;
  logic [fifoAddrW:0] freeSlots;

  logic full;
  logic emptyNow;
  logic doWrite;
  logic doRead;

  sampleT headQ;

  assign level     = wrPtr - rdPtr;
  assign freeSlots = depthLvl - level;
  assign full      = (level == depthLvl);
  assign emptyNow  = (level == '0);

  // Writes into a full buffer are lost
  assign doWrite = sampleWr.valid && !full;

  // Pop is only expected when data is present
  assign doRead = pop && !emptyNow;

  // Pointers and overflow
  always_ff @(posedge ipClk) begin
    if (!rstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      overflow <= 1'b0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Sticky until reset
      if (sampleWr.valid && full) begin
        overflow <= 1'b1;
      end
    end
  end

  // Status registers, one cycle behind the pointers
  always_ff @(posedge ipClk) begin
    if (!rstN) begin
      fifoSpace <= {depthLvl, 1'b0};
      fifoEmpty <= 1'b1;
    end else begin
      // Two bytes per free sample slot
      fifoSpace <= {freeSlots, 1'b0};
      fifoEmpty <= emptyNow;
    end
  end

  // RAM write port and registered read port
  always_ff @(posedge ipClk) begin
    if (doWrite) begin
      mem[wrPtr[fifoAddrW-1:0]] <= sampleWr.data;
    end
    headQ <= mem[rdPtr[fifoAddrW-1:0]];
  end

  // Head settles together with fifoEmpty
  assign headData = headQ;

endmodule

`default_nettype wire

//--- logic/playoutPacer.sv
// ------------------------------------------------
// Playout pacer
// Pops one sample per fixed period and presents
// it as a single-cycle output strobe
// ------------------------------------------------

`timescale 1ns/1ps
`include "audio_rx_defs.svh"
`default_nettype none

module playoutPacer
  import audioRxPkg::*;
#(
  parameter int playPeriod = `PLAY_PERIOD_DEFAULT
) (
  input  wire         ipClk,
  input  wire         rstN,
  input  wire         fifoEmpty,
  input  sampleT      headData,
  output logic        pop,
  output audioSampleT sampleOut
);

  // Counter wide enough for playPeriod - 1
  localparam int cntW = $clog2(playPeriod);

  localparam logic [cntW-1:0] reloadVal = cntW'(playPeriod - 1);

  logic [cntW-1:0] periodCnt;
  logic            tick;

  logic   outValid;
  sampleT outData;

  // One tick per period
  assign tick = (periodCnt == '0);

  // Free-running down-counter, starts at reset release
  always_ff @(posedge ipClk) begin
    if (!rstN) begin
      periodCnt <= reloadVal;
    end else if (tick) begin
      periodCnt <= reloadVal;
    end else begin
      periodCnt <= periodCnt - 1'b1;
    end
  end

  // Empty FIFO on a tick skips that period
  assign pop = tick && !fifoEmpty;

  // Output strobe follows the pop by one cycle
  always_ff @(posedge ipClk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= pop;
    end
  end

  // Head sample captured as it is popped
  always_ff @(posedge ipClk) begin
    if (pop) begin
      outData <= headData;
    end
  end

  assign sampleOut = '{valid: outValid, data: outData};

endmodule

`default_nettype wire

//--- logic/audioStreamRx.sv
// ------------------------------------------------
// Audio stream receiver
// Assembler, sample FIFO and playout pacer
// ------------------------------------------------

`timescale 1ns/1ps
`include "audio_rx_defs.svh"
`default_nettype none

module audioStreamRx
  import audioRxPkg::*;
#(
  parameter int fifoAddrW  = `FIFO_ADDR_W_DEFAULT,
  parameter int playPeriod = `PLAY_PERIOD_DEFAULT
) (
  input  wire                  ipClk,
  input  wire                  rstN,
  input  rxPacketT             rxStream,
  output audioSampleT          sampleOut,
  output logic [fifoAddrW+1:0] fifoSpace,
  output logic                 overflow
);

  // Assembler to FIFO
  sampleWriteT sampleWr;

  // FIFO to pacer and back
  sampleT headData;
  logic   fifoEmpty;
  logic   pop;

  sampleAssembler i_sampleAssembler (
    .ipClk    (ipClk),
    .rstN     (rstN),
    .rxStream (rxStream),
    .sampleWr (sampleWr)
  );

  sampleFifo #(
    .fifoAddrW (fifoAddrW)
  ) i_sampleFifo (
    .ipClk     (ipClk),
    .rstN      (rstN),
    .sampleWr  (sampleWr),
    .pop       (pop),
    .headData  (headData),
    .fifoEmpty (fifoEmpty),
    .fifoSpace (fifoSpace),
    .overflow  (overflow)
  );

  playoutPacer #(
    .playPeriod (playPeriod)
  ) i_playoutPacer (
    .ipClk     (ipClk),
    .rstN      (rstN),
    .fifoEmpty (fifoEmpty),
    .headData  (headData),
    .pop       (pop),
    .sampleOut (sampleOut)
  );

endmodule

`default_nettype wire

//--- tb/tbClockGen.sv
// ------------------------------------------------
// Testbench clock and reset
// Free-running clock, reset held low at start
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 5
) (
  output logic ipClk,
  output logic rstN
);

  initial begin
    ipClk = 1'b0;
    forever #(periodNs / 2.0) ipClk = ~ipClk;
  end

  // Release 1 ns after the last reset edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge ipClk);
    #1 rstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/audioStreamRx_sva.sv
// ------------------------------------------------
// Audio stream receiver assertions
// Strobe width, pop and reset rules, bound into
// the top level
// ------------------------------------------------

`timescale 1ns/1ps
`include "audio_rx_defs.svh"
`default_nettype none

module audioStreamRxSva
  import audioRxPkg::*;
#(
  parameter int fifoAddrW = `FIFO_ADDR_W_DEFAULT
) (
  input wire                 ipClk,
  input wire                 rstN,
  input audioSampleT         sampleOut,
  input wire                 pop,
  input wire                 fifoEmpty,
  input wire [fifoAddrW+1:0] fifoSpace,
  input wire                 overflow
);

  localparam logic [fifoAddrW+1:0] fullSpace = (fifoAddrW + 2)'(2 << fifoAddrW);

  // Count of assertion failures
  int assertFails = 0;

  // Output strobe is one cycle wide
  singleStrobe: assert property (@(posedge ipClk) disable iff (!rstN)
    sampleOut.valid |=> !sampleOut.valid)
    else begin
      $error("sampleOut.valid high in two consecutive cycles");
      assertFails++;
    end

  // Pacer never reads an empty FIFO
  // Space report below full means data is held
  popWithData: assert property (@(posedge ipClk) disable iff (!rstN)
    pop |-> (fifoSpace != fullSpace))
    else begin
      $error("pop while the FIFO holds no data");
      assertFails++;
    end

  // Quiet outputs and full space after a reset edge
  resetQuiet: assert property (@(posedge ipClk)
    !rstN |=> (!sampleOut.valid && !pop && !overflow && fifoEmpty &&
               (fifoSpace == fullSpace)))
    else begin
      $error("outputs not inactive after reset");
      assertFails++;
    end

endmodule

bind audioStreamRx audioStreamRxSva #(
  .fifoAddrW (fifoAddrW)
) i_audioStreamRxSva (
  .ipClk     (ipClk),
  .rstN      (rstN),
  .sampleOut (sampleOut),
  .pop       (pop),
  .fifoEmpty (fifoEmpty),
  .fifoSpace (fifoSpace),
  .overflow  (overflow)
);

`default_nettype wire

//--- tb/audioStreamRxTb.sv
// ------------------------------------------------
// Audio stream receiver testbench
// LFSR packet stimulus checked against a cycle
// model of pairing, FIFO depth and playout
// ------------------------------------------------

`timescale 1ns/1ps
`include "audio_rx_defs.svh"
`default_nettype none

module audioStreamRxTb
  import audioRxPkg::*;
();

  localparam int addrW  = 5;
  localparam int period = 40;
  localparam int depth  = 1 << addrW;

  typedef logic [addrW+1:0] spaceT;

  wire         ipClk;
  wire         rstN;
  rxPacketT    rxStream;
  audioSampleT sampleOut;
  spaceT       fifoSpace;
  logic        overflow;

  tbClockGen #(.periodNs(8), .resetCycles(5)) i_tbClockGen (.ipClk(ipClk), .rstN(rstN));

  audioStreamRx #(
    .fifoAddrW  (addrW),
    .playPeriod (period)
  ) i_audioStreamRx (
    .ipClk     (ipClk),
    .rstN      (rstN),
    .rxStream  (rxStream),
    .sampleOut (sampleOut),
    .fifoSpace (fifoSpace),
    .overflow  (overflow)
  );

  logic [31:0] lfsrState = 32'h2999_9a6b;
  int errors = 0, checks = 0, samplesSeen = 0, dropped = 0, gapChecks = 0;
  int cyc = 0, lastOutCyc = 0, levelOld = 0;
  // Grows with every packet sent
  int limitCyc = 1000;

  // Model state with kept samples in FIFO order
  sampleT modelQ[$];
  sampleT pendData, expData;
  byteT   heldByte;
  pktLenT bytesLeft = '0;
  logic   pendWr = 0, inPkt = 0, lowHeld = 0, expValid = 0, modelOvf = 0;
  logic   chainCur = 0, chainPrev = 0, spaceReq = 0, ovfReq = 0, popNow, wrNow;

  // 32-bit Galois step with maximal-length taps
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int takeBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = (v << 1) | int'(lfsrState[0]);
    end
    return v;
  endfunction

  // Any port except the audio one
  function automatic portT foreignPort();
    portT p;
    p = portT'(takeBits(8));
    return (p == `AUDIO_DEST_PORT) ? (p ^ 8'h01) : p;
  endfunction

  task automatic checkSample(input sampleT got, input sampleT exp);
    checks++;
    samplesSeen++;
    if (got !== exp) begin
      $display("FAILED sampleOut.data got 0x%04h expected 0x%04h", got, exp);
      errors++;
    end else begin
      $display("sample %0d 0x%04h ok", samplesSeen, got);
    end
  endtask

  task automatic checkSpace(input spaceT got, input spaceT exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED fifoSpace got 0x%02h expected 0x%02h", got, exp);
      errors++;
    end else begin
      $display("fifoSpace 0x%02h ok", got);
    end
  endtask

  task automatic checkOverflow(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED overflow got 0x%0h expected 0x%0h", got, exp);
      errors++;
    end else begin
      $display("overflow 0x%0h ok", got);
    end
  endtask

  // Cycle model checks outputs before the edge updates it
  always @(posedge ipClk) begin
    if (rstN) begin
      cyc++;
      if (sampleOut.valid !== expValid) begin
        $display("FAILED sampleOut.valid got 0x%0h expected 0x%0h at cycle %0d",
                 sampleOut.valid, expValid, cyc);
        errors++;
      end else if (expValid) begin
        checkSample(sampleOut.data, expData);
        if (chainPrev) begin
          gapChecks++;
          if (cyc - lastOutCyc != period) begin
            $display("Sample came %0d cycles after the previous one instead of %0d",
                     cyc - lastOutCyc, period);
            errors++;
          end
        end
        chainPrev  = chainCur;
        lastOutCyc = cyc;
      end
      if (spaceReq) begin
        checkSpace(fifoSpace, spaceT'(2 * (depth - levelOld)));
        spaceReq = 1'b0;
      end
      if (ovfReq) begin
        checkOverflow(overflow, modelOvf);
        ovfReq = 1'b0;
      end
      // Tick every period
      // Empty flag lags the level by one cycle
      popNow   = (cyc % period == 0) && (levelOld != 0);
      wrNow    = pendWr && (modelQ.size() < depth);
      levelOld = modelQ.size();
      if (popNow) expData = modelQ.pop_front();
      if (wrNow) modelQ.push_back(pendData);
      if (pendWr && !wrNow) begin
        modelOvf = 1'b1;
        dropped++;
      end
      if (popNow) chainCur = (modelQ.size() != 0);
      expValid = popNow;
      // Pairing with the low byte first
      // Odd tail left unpaired
      pendWr = 1'b0;
      if (rxStream.valid && rxStream.sop) begin
        inPkt     = (rxStream.destination == `AUDIO_DEST_PORT);
        bytesLeft = rxStream.length - 1'b1;
        heldByte  = rxStream.data;
        lowHeld   = 1'b1;
      end else if (rxStream.valid && inPkt && bytesLeft != 0) begin
        if (lowHeld) begin
          pendWr   = 1'b1;
          pendData = {rxStream.data, heldByte};
        end else begin
          heldByte = rxStream.data;
        end
        lowHeld   = !lowHeld;
        bytesLeft = bytesLeft - 1'b1;
      end
      if (cyc > limitCyc) begin
        $display("Timeout, the run did not end within %0d cycles", limitCyc);
        $display("Checks failed");
        $finish;
      end
    end
  end

  task automatic idleCycles(input int n);
    rxStream = '0;
    repeat (n) begin
      @(posedge ipClk);
      #1;
    end
    limitCyc += n;
  endtask

  task automatic sendPacket(input portT dest, input pktLenT len, input logic gaps);
    for (int i = 0; i < int'(len); i++) begin
      if (gaps && i > 0 && takeBits(2) == 0) idleCycles(1);
      rxStream = '{valid: 1'b1, sop: (i == 0), destination: dest, length: len,
                   data: byteT'(takeBits(8))};
      @(posedge ipClk);
      #1;
    end
    rxStream = '0;
    limitCyc += 2 * (int'(len) + ((dest == `AUDIO_DEST_PORT) ? (int'(len) / 2) * period : 0));
  endtask

  task automatic requestChecks(input logic space, input logic ovf);
    spaceReq = space;
    ovfReq   = ovf;
    @(posedge ipClk);
    #1;
  endtask

  // Idle input until the model has played everything
  task automatic drainAndCheck();
    rxStream = '0;
    while (modelQ.size() != 0 || levelOld != 0 || pendWr || expValid) begin
      @(posedge ipClk);
      #1;
    end
    requestChecks(1'b1, 1'b1);
  endtask

  initial begin
    int t0;
    rxStream = '0;
    @(posedge rstN);
    requestChecks(1'b1, 1'b1);
    t0 = errors;
    repeat (4) sendPacket(`AUDIO_DEST_PORT, pktLenT'(2 + 2 * (takeBits(3) % 6)), 1'b1);
    drainAndCheck();
    $display("Test even audio packets done, %0d errors", errors - t0);
    t0 = errors;
    repeat (6) sendPacket(foreignPort(), pktLenT'(1 + takeBits(4)), 1'b1);
    requestChecks(1'b1, 1'b0);
    repeat (10) begin
      if (takeBits(1) == 1) sendPacket(`AUDIO_DEST_PORT, pktLenT'(2 + 2 * takeBits(1)), 1'b1);
      else sendPacket(foreignPort(), pktLenT'(1 + takeBits(4)), 1'b1);
    end
    drainAndCheck();
    $display("Test foreign ports interleaved done, %0d errors", errors - t0);
    t0 = errors;
    repeat (5) begin
      sendPacket(`AUDIO_DEST_PORT, pktLenT'(1 + 2 * (takeBits(3) % 6)), (takeBits(1) == 1));
    end
    drainAndCheck();
    $display("Test odd-length packets done, %0d errors", errors - t0);
    t0 = errors;
    repeat (3) sendPacket(`AUDIO_DEST_PORT, pktLenT'(16), 1'b0);
    drainAndCheck();
    $display("Test playout pacing done, %0d intervals, %0d errors", gapChecks, errors - t0);
    t0 = errors;
    repeat (2) sendPacket(`AUDIO_DEST_PORT, pktLenT'(16), 1'b0);
    idleCycles(100);
    requestChecks(1'b1, 1'b0);
    idleCycles(60);
    requestChecks(1'b1, 1'b0);
    drainAndCheck();
    $display("Test space between bursts done, %0d errors", errors - t0);
    t0 = errors;
    repeat (6) sendPacket(`AUDIO_DEST_PORT, pktLenT'(16), 1'b0);
    idleCycles(2);
    requestChecks(1'b0, 1'b1);
    drainAndCheck();
    if (dropped == 0) begin
      $display("The burst beyond the FIFO depth lost no samples");
      errors++;
    end
    $display("Test overflow burst done, %0d dropped, %0d errors", dropped, errors - t0);
    errors += i_audioStreamRx.i_audioStreamRxSva.assertFails;
    $display("Totals: %0d checks, %0d samples, %0d errors", checks, samplesSeen, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/audioRxPkg.sv
logic/sampleAssembler.sv
logic/sampleFifo.sv
logic/playoutPacer.sv
logic/audioStreamRx.sv
tb/tbClockGen.sv
tb/audioStreamRx_sva.sv
tb/audioStreamRxTb.sv
